//--- hw/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Widths and reset address
`define RV_XLEN        32
`define RV_RESET_ADDR  32'h0000_0000
`define RV_REG_AW      5

// Instruction queue sizing, depth must be a power of two
`define RV_QUEUE_DEPTH 4
`define RV_QUEUE_AW    2

// Major opcodes kept by the core
`define RV_OPC_OP      7'b0110011
`define RV_OPC_OP_IMM  7'b0010011
`define RV_OPC_LUI     7'b0110111

// ALU funct3 codes
`define RV_F3_ADD      3'b000
`define RV_F3_SLL      3'b001
`define RV_F3_SLT      3'b010
`define RV_F3_SLTU     3'b011
`define RV_F3_XOR      3'b100
`define RV_F3_SR       3'b101
`define RV_F3_OR       3'b110
`define RV_F3_AND      3'b111

`endif

//--- hw/rv_pkg.sv
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

	// R-type view, register-register ALU ops
	typedef struct packed {
		logic [6:0]            funct7;
		logic [`RV_REG_AW-1:0] rs2;
		logic [`RV_REG_AW-1:0] rs1;
		logic [2:0]            funct3;
		logic [`RV_REG_AW-1:0] rd;
		logic [6:0]            opcode;
	} r_fmt_t;

	// I-type view, immediate ALU ops
	typedef struct packed {
		logic [11:0]           imm12;
		logic [`RV_REG_AW-1:0] rs1;
		logic [2:0]            funct3;
		logic [`RV_REG_AW-1:0] rd;
		logic [6:0]            opcode;
	} i_fmt_t;

	// U-type view, LUI
	typedef struct packed {
		logic [19:0]           imm20;
		logic [`RV_REG_AW-1:0] rd;
		logic [6:0]            opcode;
	} u_fmt_t;

	// One fetched word, read through the view its opcode selects
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		u_fmt_t u;
	} instr_t;

endpackage

`default_nettype wire

//--- hw/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_fetch (
	input  wire                 clk_i,
	input  wire                 rst_n_i,
	input  wire                 imem_ack_i,
	input  wire [`RV_XLEN-1:0]  imem_rdata_i,
	input  wire                 full_i,
	output logic                imem_req_o,
	output logic [`RV_XLEN-1:0] imem_addr_o,
	output logic                push_o,
	output rv_pkg::instr_t      push_word_o,
	output logic [`RV_XLEN-1:0] push_pc_o
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_REQ  = 2'd1;
	localparam logic [1:0] ST_REL  = 2'd2;

	logic [1:0]          state;
	logic [1:0]          state_nxt;
	logic [`RV_XLEN-1:0] pc;

	// ------------------------------------------------------------------------
	// Four-phase handshake FSM
	// ------------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				// Only start a new fetch when the queue can take it
				if (!full_i)
					state_nxt = ST_REQ;
			end
			ST_REQ: begin
				if (imem_ack_i)
					state_nxt = ST_REL;
			end
			ST_REL: begin
				// Wait for ack to fall before the next request
				if (!imem_ack_i)
					state_nxt = full_i ? ST_IDLE : ST_REQ;
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= ST_IDLE;
			pc    <= `RV_RESET_ADDR;
		end else begin
			state <= state_nxt;
			if (push_o)
				pc <= pc + `RV_XLEN'(4);
		end
	end

	// Address held stable for the whole request phase
	assign imem_req_o  = (state == ST_REQ);
	assign imem_addr_o = pc;

	// Word goes to the queue in the first cycle ack is seen
	assign push_o      = (state == ST_REQ) && imem_ack_i;
	assign push_word_o = imem_rdata_i;
	assign push_pc_o   = pc;

endmodule

`default_nettype wire

//--- hw/rv_inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_inst_queue (
	input  wire                 clk_i,
	input  wire                 rst_n_i,
	input  wire                 push_i,
	input  wire rv_pkg::instr_t push_word_i,
	input  wire [`RV_XLEN-1:0]  push_pc_i,
	input  wire                 pop_i,
	output logic                full_o,
	output logic                empty_o,
	output rv_pkg::instr_t      head_word_o,
	output logic [`RV_XLEN-1:0] head_pc_o
);

	rv_pkg::instr_t      word_mem [`RV_QUEUE_DEPTH];
	logic [`RV_XLEN-1:0] pc_mem   [`RV_QUEUE_DEPTH];

	logic [`RV_QUEUE_AW-1:0] wr_ptr;
	logic [`RV_QUEUE_AW-1:0] rd_ptr;
	logic [`RV_QUEUE_AW:0]   count;

	// Storage, written at the tail
	always_ff @(posedge clk_i) begin
		if (push_i) begin
			word_mem[wr_ptr] <= push_word_i;
			pc_mem[wr_ptr]   <= push_pc_i;
		end
	end

	// Pointers wrap naturally at the power-of-two depth
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_i)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push_i, pop_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign full_o  = (count == (`RV_QUEUE_AW+1)'(`RV_QUEUE_DEPTH));
	assign empty_o = (count == '0);

	// Head is read straight out of storage
	assign head_word_o = word_mem[rd_ptr];
	assign head_pc_o   = pc_mem[rd_ptr];

endmodule

`default_nettype wire

//--- hw/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_decode (
	input  wire rv_pkg::instr_t       word_i,
	output logic [`RV_REG_AW-1:0]     rs1_o,
	output logic [`RV_REG_AW-1:0]     rs2_o,
	output logic [`RV_REG_AW-1:0]     rd_o,
	output logic [2:0]                funct3_o,
	output logic                      alt_o,
	output logic                      use_imm_o,
	output logic                      is_lui_o,
	output logic [`RV_XLEN-1:0]       imm_o,
	output logic                      illegal_o
);

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	always_comb begin
		rs1_o     = '0;
		rs2_o     = '0;
		rd_o      = word_i.r.rd;
		funct3_o  = word_i.r.funct3;
		alt_o     = 1'b0;
		use_imm_o = 1'b0;
		is_lui_o  = 1'b0;
		imm_o     = '0;
		illegal_o = 1'b0;

		case (word_i.r.opcode)
			`RV_OPC_OP: begin
				rs1_o    = word_i.r.rs1;
				rs2_o    = word_i.r.rs2;
				alt_o    = word_i.r.funct7[5];
				// Alternate encoding only exists for sub and sra
				if (word_i.r.funct7 == F7_ALT)
					illegal_o = (word_i.r.funct3 != `RV_F3_ADD) &&
						(word_i.r.funct3 != `RV_F3_SR);
				else
					illegal_o = (word_i.r.funct7 != F7_BASE);
			end
			`RV_OPC_OP_IMM: begin
				rs1_o     = word_i.i.rs1;
				use_imm_o = 1'b1;
				imm_o     = {{(`RV_XLEN-12){word_i.i.imm12[11]}}, word_i.i.imm12};
				// Shift immediates carry funct7 in the upper imm bits
				if (word_i.i.funct3 == `RV_F3_SLL)
					illegal_o = (word_i.i.imm12[11:5] != F7_BASE);
				else if (word_i.i.funct3 == `RV_F3_SR) begin
					alt_o     = word_i.i.imm12[10];
					illegal_o = (word_i.i.imm12[11:5] != F7_BASE) &&
						(word_i.i.imm12[11:5] != F7_ALT);
				end
			end
			`RV_OPC_LUI: begin
				is_lui_o = 1'b1;
				imm_o    = {word_i.u.imm20, 12'b0};
			end
			default: illegal_o = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_regfile (
	input  wire                  clk_i,
	input  wire                  rst_n_i,
	input  wire [`RV_REG_AW-1:0] rs1_i,
	input  wire [`RV_REG_AW-1:0] rs2_i,
	input  wire                  we_i,
	input  wire [`RV_REG_AW-1:0] wa_i,
	input  wire [`RV_XLEN-1:0]   wd_i,
	output logic [`RV_XLEN-1:0]  rd1_o,
	output logic [`RV_XLEN-1:0]  rd2_o
);

	logic [`RV_XLEN-1:0] regs [2**`RV_REG_AW];

	// Single write port, x0 never written
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < 2**`RV_REG_AW; i++)
				regs[i] <= '0;
		end else if (we_i && (wa_i != '0)) begin
			regs[wa_i] <= wd_i;
		end
	end

	// Combinational reads, x0 forced to zero
	assign rd1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
	assign rd2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

//--- hw/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_execute (
	input  wire                   clk_i,
	input  wire                   rst_n_i,
	input  wire                   exec_en_i,
	input  wire                   empty_i,
	input  wire rv_pkg::instr_t   head_word_i,
	input  wire [`RV_XLEN-1:0]    head_pc_i,
	output logic                  pop_o,
	output logic                  retire_valid_o,
	output logic [`RV_XLEN-1:0]   retire_pc_o,
	output logic [`RV_REG_AW-1:0] retire_rd_o,
	output logic [`RV_XLEN-1:0]   retire_data_o,
	output logic                  retire_illegal_o
);

	logic [`RV_REG_AW-1:0] rs1;
	logic [`RV_REG_AW-1:0] rs2;
	logic [`RV_REG_AW-1:0] rd;
	logic [2:0]            funct3;
	logic                  alt;
	logic                  use_imm;
	logic                  is_lui;
	logic                  illegal;
	logic [`RV_XLEN-1:0]   imm;
	logic [`RV_XLEN-1:0]   op_a;
	logic [`RV_XLEN-1:0]   op_b;
	logic [`RV_XLEN-1:0]   op_b_reg;
	logic [`RV_XLEN-1:0]   result;
	logic [4:0]            shamt;

	rv_decode u_decode (
		.word_i    (head_word_i),
		.rs1_o     (rs1),
		.rs2_o     (rs2),
		.rd_o      (rd),
		.funct3_o  (funct3),
		.alt_o     (alt),
		.use_imm_o (use_imm),
		.is_lui_o  (is_lui),
		.imm_o     (imm),
		.illegal_o (illegal)
	);

	// Write lands on the retire edge, so the next pop reads fresh data
	rv_regfile u_regfile (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.rs1_i   (rs1),
		.rs2_i   (rs2),
		.we_i    (pop_o && !illegal),
		.wa_i    (rd),
		.wd_i    (result),
		.rd1_o   (op_a),
		.rd2_o   (op_b_reg)
	);

	assign pop_o = exec_en_i && !empty_i;
	assign op_b  = use_imm ? imm : op_b_reg;
	assign shamt = op_b[4:0];

	// ------------------------------------------------------------------------
	// ALU
	// ------------------------------------------------------------------------
	always_comb begin
		case (funct3)
			`RV_F3_ADD:  result = alt ? (op_a - op_b) : (op_a + op_b);
			`RV_F3_SLL:  result = op_a << shamt;
			`RV_F3_SLT:  result = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			`RV_F3_SLTU: result = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
			`RV_F3_XOR:  result = op_a ^ op_b;
			`RV_F3_SR:   result = alt ? `RV_XLEN'($signed(op_a) >>> shamt) : (op_a >> shamt);
			`RV_F3_OR:   result = op_a | op_b;
			default:     result = op_a & op_b;
		endcase
		// LUI bypasses the ALU
		if (is_lui)
			result = imm;
	end

	// Retire pulse follows the pop by one cycle
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			retire_valid_o <= 1'b0;
		else
			retire_valid_o <= pop_o;
	end

	always_ff @(posedge clk_i) begin
		if (pop_o) begin
			retire_pc_o      <= head_pc_i;
			retire_rd_o      <= rd;
			retire_data_o    <= illegal ? '0 : result;
			retire_illegal_o <= illegal;
		end
	end

endmodule

`default_nettype wire

//--- hw/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_core (
	input  wire                   clk_i,
	input  wire                   rst_n_i,
	input  wire                   exec_en_i,
	input  wire                   imem_ack_i,
	input  wire [`RV_XLEN-1:0]    imem_rdata_i,
	output logic                  imem_req_o,
	output logic [`RV_XLEN-1:0]   imem_addr_o,
	output logic                  retire_valid_o,
	output logic [`RV_XLEN-1:0]   retire_pc_o,
	output logic [`RV_REG_AW-1:0] retire_rd_o,
	output logic [`RV_XLEN-1:0]   retire_data_o,
	output logic                  retire_illegal_o
);

	// Fetch to queue
	logic                push;
	rv_pkg::instr_t      push_word;
	logic [`RV_XLEN-1:0] push_pc;
	logic                full;

	// Queue to execute
	logic                pop;
	logic                empty;
	rv_pkg::instr_t      head_word;
	logic [`RV_XLEN-1:0] head_pc;

	rv_fetch u_fetch (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.imem_ack_i   (imem_ack_i),
		.imem_rdata_i (imem_rdata_i),
		.full_i       (full),
		.imem_req_o   (imem_req_o),
		.imem_addr_o  (imem_addr_o),
		.push_o       (push),
		.push_word_o  (push_word),
		.push_pc_o    (push_pc)
	);

	rv_inst_queue u_queue (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.push_i      (push),
		.push_word_i (push_word),
		.push_pc_i   (push_pc),
		.pop_i       (pop),
		.full_o      (full),
		.empty_o     (empty),
		.head_word_o (head_word),
		.head_pc_o   (head_pc)
	);

	rv_execute u_execute (
		.clk_i            (clk_i),
		.rst_n_i          (rst_n_i),
		.exec_en_i        (exec_en_i),
		.empty_i          (empty),
		.head_word_i      (head_word),
		.head_pc_i        (head_pc),
		.pop_o            (pop),
		.retire_valid_o   (retire_valid_o),
		.retire_pc_o      (retire_pc_o),
		.retire_rd_o      (retire_rd_o),
		.retire_data_o    (retire_data_o),
		.retire_illegal_o (retire_illegal_o)
	);

endmodule

`default_nettype wire

//--- tests/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module tb_rv_core;

	localparam int PROG_LEN = 96;

	logic                  clk_i = 1'b0;
	logic                  rst_n_i;
	logic                  exec_en_i;
	logic                  imem_ack_i;
	logic [`RV_XLEN-1:0]   imem_rdata_i;
	logic                  imem_req_o;
	logic [`RV_XLEN-1:0]   imem_addr_o;
	logic                  retire_valid_o;
	logic [`RV_XLEN-1:0]   retire_pc_o;
	logic [`RV_REG_AW-1:0] retire_rd_o;
	logic [`RV_XLEN-1:0]   retire_data_o;
	logic                  retire_illegal_o;

	logic [`RV_XLEN-1:0] prog [PROG_LEN];
	logic [`RV_XLEN-1:0] ref_regs [2**`RV_REG_AW];
	logic [31:0]         rng_state = 32'h83983901;
	int                  hs_count = 0;
	int                  retire_count = 0;

	rv_core uut (
		.clk_i            (clk_i),
		.rst_n_i          (rst_n_i),
		.exec_en_i        (exec_en_i),
		.imem_ack_i       (imem_ack_i),
		.imem_rdata_i     (imem_rdata_i),
		.imem_req_o       (imem_req_o),
		.imem_addr_o      (imem_addr_o),
		.retire_valid_o   (retire_valid_o),
		.retire_pc_o      (retire_pc_o),
		.retire_rd_o      (retire_rd_o),
		.retire_data_o    (retire_data_o),
		.retire_illegal_o (retire_illegal_o)
	);

	always #10 clk_i = ~clk_i;

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [`RV_XLEN-1:0] got,
			input logic [`RV_XLEN-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: %s expected %h got %h", $time, name, exp, got));
	endtask

	task automatic check_reg(input string name, input logic [`RV_REG_AW-1:0] got,
			input logic [`RV_REG_AW-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: %s expected %0d got %0d", $time, name, exp, got));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: %s expected %b got %b", $time, name, exp, got));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Program word, or an illegal fill word past the end of the program
	function automatic logic [`RV_XLEN-1:0] mem_word(input logic [`RV_XLEN-1:0] addr);
		logic [`RV_XLEN-1:0] idx;
		idx = (addr - `RV_RESET_ADDR) >> 2;
		if (idx < PROG_LEN)
			return prog[idx];
		return {addr[26:2] ^ addr[31:7], 7'h7f};
	endfunction

	// ------------------------------------------------------------------------
	// Program generator
	// ------------------------------------------------------------------------
	function automatic logic [`RV_XLEN-1:0] gen_instr();
		rv_pkg::instr_t w;
		logic [31:0]    r;
		logic [3:0]     kind;
		r    = next_rand();
		kind = r[3:0];
		w    = next_rand();
		// Small register range so results feed later instructions
		w.r.rd  = {2'b00, r[6:4]};
		w.r.rs1 = {2'b00, r[9:7]};
		w.r.rs2 = {2'b00, r[12:10]};
		if (kind < 6 || kind == 15) begin
			w.r.opcode = `RV_OPC_OP;
			if (r[13] && (w.r.funct3 == `RV_F3_ADD || w.r.funct3 == `RV_F3_SR))
				w.r.funct7 = 7'h20;
			else
				w.r.funct7 = 7'h00;
		end else if (kind < 12) begin
			w.i.opcode = `RV_OPC_OP_IMM;
			if (w.i.funct3 == `RV_F3_SLL)
				w.i.imm12[11:5] = 7'h00;
			else if (w.i.funct3 == `RV_F3_SR)
				w.i.imm12[11:5] = r[13] ? 7'h20 : 7'h00;
		end else if (kind < 14) begin
			w.u.opcode = `RV_OPC_LUI;
		end else begin
			// A few illegal encodings
			case (r[15:14])
				2'd0: w.r.opcode = 7'h63;
				2'd1: w.r.opcode = 7'h03;
				2'd2: begin
					w.r.opcode = `RV_OPC_OP;
					w.r.funct7 = 7'h01;
				end
				default: begin
					w.i.opcode      = `RV_OPC_OP_IMM;
					w.i.funct3      = `RV_F3_SLL;
					w.i.imm12[11:5] = 7'h10;
				end
			endcase
		end
		return w;
	endfunction

	// ------------------------------------------------------------------------
	// Reference model runs one instruction against ref_regs
	// ------------------------------------------------------------------------
	function automatic void ref_exec(input rv_pkg::instr_t w,
			output logic [`RV_REG_AW-1:0] rd, output logic [`RV_XLEN-1:0] data,
			output logic illegal);
		logic [`RV_XLEN-1:0]        a;
		logic [`RV_XLEN-1:0]        b;
		logic [`RV_XLEN-1:0]        res;
		logic signed [`RV_XLEN-1:0] sra;
		logic                       alt;
		rd      = w.r.rd;
		data    = '0;
		illegal = 1'b0;
		alt     = 1'b0;
		a       = ref_regs[w.r.rs1];
		b       = ref_regs[w.r.rs2];
		case (w.r.opcode)
			`RV_OPC_OP: begin
				if (w.r.funct7 == 7'h20) begin
					alt     = 1'b1;
					illegal = !(w.r.funct3 == `RV_F3_ADD || w.r.funct3 == `RV_F3_SR);
				end else begin
					illegal = (w.r.funct7 != 7'h00);
				end
			end
			`RV_OPC_OP_IMM: begin
				b = {{(`RV_XLEN-12){w.i.imm12[11]}}, w.i.imm12};
				if (w.i.funct3 == `RV_F3_SLL) begin
					illegal = (w.i.imm12[11:5] != 7'h00);
				end else if (w.i.funct3 == `RV_F3_SR) begin
					alt     = (w.i.imm12[11:5] == 7'h20);
					illegal = !alt && (w.i.imm12[11:5] != 7'h00);
				end
			end
			`RV_OPC_LUI: ;
			default: illegal = 1'b1;
		endcase
		sra = $signed(a) >>> b[4:0];
		case (w.r.funct3)
			`RV_F3_ADD:  res = alt ? a - b : a + b;
			`RV_F3_SLL:  res = a << b[4:0];
			`RV_F3_SLT:  res = ($signed(a) < $signed(b)) ? 1 : 0;
			`RV_F3_SLTU: res = (a < b) ? 1 : 0;
			`RV_F3_XOR:  res = a ^ b;
			`RV_F3_SR:   res = alt ? sra : a >> b[4:0];
			`RV_F3_OR:   res = a | b;
			default:     res = a & b;
		endcase
		if (w.r.opcode == `RV_OPC_LUI)
			res = {w.u.imm20, 12'b0};
		if (!illegal) begin
			data = res;
			if (rd != '0)
				ref_regs[rd] = res;
		end
	endfunction

	// ------------------------------------------------------------------------
	// Instruction memory model as a four-phase slave
	// ------------------------------------------------------------------------
	logic [`RV_XLEN-1:0] req_addr = '0;
	logic                prev_req = 1'b0;
	logic [31:0]         ack_delay = '0;
	logic [31:0]         rel_delay = '0;

	always @(negedge clk_i) begin
		if (imem_req_o === 1'b1 && imem_ack_i) begin
			if (!prev_req)
				abort_run("Fetch raised imem_req_o while imem_ack_i was still high");
			else
				abort_run("Fetch kept imem_req_o high after imem_ack_i");
		end else if (imem_req_o === 1'b1) begin
			if (!prev_req) begin
				req_addr  = imem_addr_o;
				ack_delay = next_rand() & 32'h3;
				check_word("imem_addr_o", imem_addr_o,
					`RV_RESET_ADDR + `RV_XLEN'(4 * hs_count));
			end else if (imem_addr_o !== req_addr) begin
				abort_run("imem_addr_o changed while imem_req_o was high");
			end
			if (ack_delay == 0) begin
				imem_rdata_i = mem_word(req_addr);
				imem_ack_i   = 1'b1;
				hs_count     = hs_count + 1;
				rel_delay    = next_rand() & 32'h3;
			end else begin
				ack_delay = ack_delay - 1;
			end
		end else if (imem_ack_i) begin
			if (rel_delay == 0)
				imem_ack_i = 1'b0;
			else
				rel_delay = rel_delay - 1;
		end
		prev_req = (imem_req_o === 1'b1);
	end

	// Retire checker
	always @(negedge clk_i) begin
		logic [`RV_XLEN-1:0]   exp_pc;
		logic [`RV_XLEN-1:0]   exp_data;
		logic [`RV_REG_AW-1:0] exp_rd;
		logic                  exp_ill;
		if (retire_valid_o === 1'b1) begin
			exp_pc = `RV_RESET_ADDR + `RV_XLEN'(4 * retire_count);
			ref_exec(mem_word(exp_pc), exp_rd, exp_data, exp_ill);
			check_word("retire_pc_o", retire_pc_o, exp_pc);
			check_flag("retire_illegal_o", retire_illegal_o, exp_ill);
			if (!exp_ill)
				check_reg("retire_rd_o", retire_rd_o, exp_rd);
			check_word("retire_data_o", retire_data_o, exp_data);
			retire_count = retire_count + 1;
		end
	end

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial begin
		int cycles;
		rst_n_i      = 1'b0;
		exec_en_i    = 1'b0;
		imem_ack_i   = 1'b0;
		imem_rdata_i = '0;
		for (int i = 0; i < 2**`RV_REG_AW; i++)
			ref_regs[i] = '0;
		for (int i = 0; i < PROG_LEN; i++)
			prog[i] = gen_instr();

		repeat (5) begin
			@(negedge clk_i);
			check_flag("imem_req_o", imem_req_o, 1'b0);
			check_flag("retire_valid_o", retire_valid_o, 1'b0);
		end
		rst_n_i = 1'b1;

		// Queue fills up while execute is stalled
		cycles = 0;
		while (!(hs_count == `RV_QUEUE_DEPTH && !imem_ack_i)) begin
			@(posedge clk_i);
			cycles++;
			if (cycles > 200)
				abort_run("Timeout waiting for the queue to fill while exec_en_i was low");
		end
		repeat (50) begin
			@(negedge clk_i);
			check_flag("imem_req_o", imem_req_o, 1'b0);
			check_flag("retire_valid_o", retire_valid_o, 1'b0);
		end

		@(negedge clk_i);
		exec_en_i = 1'b1;

		cycles = 0;
		while (retire_count < PROG_LEN) begin
			@(posedge clk_i);
			cycles++;
			if (cycles > PROG_LEN * 16)
				abort_run("Timeout waiting for the program to retire");
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+hw
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_inst_queue.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_core.sv
tests/tb_rv_core.sv
